// ==== bench/apbMem.sv ====
`timescale 1ns/1ps

module apbMem #(
  parameter int          words = 256,
  parameter logic [31:0] seed  = 32'd75
) (
  input  logic          clk,
  input  logic          arstN,
  input  rvPkg::apbReqT req,
  output rvPkg::apbRspT rsp
);

  logic [31:0]              mem [words];
  logic [31:0]              rnd;
  logic [1:0]               waitCnt;
  logic [$clog2(words)-1:0] idx;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // fill pattern mixes every address bit
  initial begin
    for (int i = 0; i < words; i++) begin
      mem[i] <= (32'(i) * 32'h9E3779B1) ^ 32'hA5A5_0000;
    end
  end

  assign idx         = req.paddr[$clog2(words)+1:2];
  assign rsp.prdata  = mem[idx];
  assign rsp.pready  = (waitCnt == 2'd0);
  assign rsp.pslverr = 1'b0;

  // wait states drawn on each setup phase
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rnd     <= seed;
      waitCnt <= 2'd0;
    end else if (req.psel && !req.penable) begin
      waitCnt <= rnd[1:0];
      rnd     <= xorshift(rnd);
    end else if (req.psel && req.penable && waitCnt != 2'd0) begin
      waitCnt <= waitCnt - 2'd1;
    end
  end

  always @(posedge clk) begin
    if (req.psel && req.penable && rsp.pready && req.pwrite) begin
      for (int b = 0; b < 4; b++) begin
        if (req.pstrb[b]) begin
          mem[idx][8*b +: 8] <= req.pwdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// ==== bench/tbRvCore.sv ====
`timescale 1ns/1ps

module tbRvCore;

  import rvPkg::*;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [2:0]  test;
  } storeT;

  localparam logic [6:0] oOp     = 7'b0110011;
  localparam logic [6:0] oOpImm  = 7'b0010011;
  localparam logic [6:0] oLoad   = 7'b0000011;
  localparam logic [6:0] oJalr   = 7'b1100111;
  localparam logic [6:0] oLui    = 7'b0110111;
  localparam logic [6:0] oAuipc  = 7'b0010111;
  localparam logic [6:0] oSystem = 7'b1110011;
  localparam logic [31:0] base   = 32'h100;

  logic   clk;
  logic   arstN;
  apbReqT iReq;
  apbRspT iRsp;
  apbReqT dReq;
  apbRspT dRsp;
  logic   halted;

  storeT       expQ[$];
  logic [31:0] progPc;
  logic [31:0] nextOff;
  int          testErr[6];
  bit          reported[6];
  int          passCount;
  int          failCount;
  int          strayErr;
  apbReqT      prevI;
  apbReqT      prevD;
  bit          waitI;
  bit          waitD;
  string       names[6] = '{"arith", "branch", "byteHalf", "csrTrap", "halt", "stable"};

  rvCore #(.resetPc(32'h0)) i_dut (
    .clk(clk), .arstN(arstN), .iReq(iReq), .iRsp(iRsp),
    .dReq(dReq), .dRsp(dRsp), .halted(halted)
  );

  apbMem #(.seed(32'd75)) iMem (.clk(clk), .arstN(arstN), .req(iReq), .rsp(iRsp));
  apbMem #(.seed(32'd75)) dMem (.clk(clk), .arstN(arstN), .req(dReq), .rsp(dRsp));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // RV32I instruction formats
  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, oOp};
  endfunction

  function automatic logic [31:0] encI(input logic [31:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encS(input logic [31:0] imm, input logic [4:0] rs2,
                                       input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd10, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] encB(input logic [31:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] encJ(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] strbMask(input logic [3:0] s);
    return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
  endfunction

  task automatic put(input logic [31:0] w);
    iMem.mem[progPc[9:2]] <= w;
    progPc = progPc + 32'd4;
  endtask

  // store expecting a bus write with its data in the byte lanes
  task automatic storeAt(input logic [4:0] rs2, input logic [2:0] f3, input logic [31:0] off,
                         input logic [31:0] data, input logic [3:0] strb, input int t);
    storeT e;
    put(encS(off, rs2, f3));
    e = '{addr: base + off, data: data, strb: strb, test: 3'(t)};
    expQ.push_back(e);
  endtask

  task automatic storeWord(input logic [4:0] rs2, input logic [31:0] data, input int t);
    storeAt(rs2, 3'b010, nextOff, data, 4'hF, t);
    nextOff = nextOff + 32'd4;
  endtask

  // store on a path the core must skip
  task automatic storeWrong(input logic [4:0] rs2);
    put(encS(32'h0F0, rs2, 3'b010));
  endtask

  task automatic reportTest(input int t);
    reported[t] = 1'b1;
    if (testErr[t] == 0) begin
      passCount++;
      $display("test %s: pass", names[t]);
    end else begin
      failCount++;
      $display("test %s: fail with %0d errors", names[t], testErr[t]);
    end
  endtask

  task automatic buildProgram();
    logic [31:0] p;
    logic [31:0] saved;
    progPc  = 32'h0;
    nextOff = 32'h0;
    put(encI(32'h100, 0, 3'b000, 10, oOpImm));
    put(encI(32'd100, 0, 3'b000, 1, oOpImm));
    put(encI(-32'sd7, 0, 3'b000, 2, oOpImm));
    // arithmetic on x1 = 100 and x2 = -7
    put(encR(7'h00, 2, 1, 3'b000, 3));
    storeWord(3, 32'd93, 0);
    put(encR(7'h20, 2, 1, 3'b000, 3));
    storeWord(3, 32'd107, 0);
    put(encI(32'd3, 1, 3'b001, 3, oOpImm));
    storeWord(3, 32'd800, 0);
    put(encR(7'h00, 1, 2, 3'b010, 3));
    storeWord(3, 32'd1, 0);
    put(encR(7'h00, 1, 2, 3'b011, 3));
    storeWord(3, 32'd0, 0);
    put(encI(32'hFF, 1, 3'b100, 3, oOpImm));
    storeWord(3, 32'd155, 0);
    put(encI(32'h401, 2, 3'b101, 3, oOpImm));
    storeWord(3, 32'hFFFF_FFFC, 0);
    put(encI(32'd28, 2, 3'b101, 3, oOpImm));
    storeWord(3, 32'hF, 0);
    put(encR(7'h00, 2, 1, 3'b110, 3));
    storeWord(3, 32'hFFFF_FFFD, 0);
    put(encI(32'h3C, 1, 3'b111, 3, oOpImm));
    storeWord(3, 32'h24, 0);
    put({20'hABCDE, 5'd3, oLui});
    storeWord(3, 32'hABCD_E000, 0);
    p = progPc;
    put({20'h00001, 5'd3, oAuipc});
    storeWord(3, p + 32'h1000, 0);
    // branches and jumps
    put(encB(32'd8, 1, 1, 3'b000));
    storeWrong(0);
    storeWord(1, 32'd100, 1);
    put(encB(32'd8, 1, 1, 3'b001));
    storeWord(2, 32'hFFFF_FFF9, 1);
    put(encB(32'd8, 2, 1, 3'b110));
    storeWrong(0);
    put(encB(32'd8, 1, 2, 3'b101));
    storeWord(1, 32'd100, 1);
    p = progPc;
    put(encJ(32'd8, 5));
    storeWrong(0);
    storeWord(5, p + 32'd4, 1);
    p = progPc;
    put({20'h0, 5'd6, oAuipc});
    put(encI(32'd13, 6, 3'b000, 7, oJalr));
    storeWrong(0);
    storeWord(7, p + 32'd8, 1);
    // byte and half lanes with x8 = 0xFFFFFF94
    put(encI(-32'sh6C, 0, 3'b000, 8, oOpImm));
    storeAt(0, 3'b010, 32'h80, 32'h0, 4'b1111, 2);
    storeAt(8, 3'b000, 32'h81, 32'h0000_9400, 4'b0010, 2);
    storeAt(8, 3'b001, 32'h82, 32'hFF94_0000, 4'b1100, 2);
    put(encI(32'h81, 10, 3'b000, 9, oLoad));
    storeWord(9, 32'hFFFF_FF94, 2);
    put(encI(32'h81, 10, 3'b100, 9, oLoad));
    storeWord(9, 32'h94, 2);
    put(encI(32'h82, 10, 3'b001, 9, oLoad));
    storeWord(9, 32'hFFFF_FF94, 2);
    put(encI(32'h82, 10, 3'b101, 9, oLoad));
    storeWord(9, 32'hFF94, 2);
    put(encI(32'h80, 10, 3'b010, 9, oLoad));
    storeWord(9, 32'hFF94_9400, 2);
    // trap vector at 0x200
    put(encI(32'h200, 0, 3'b000, 11, oOpImm));
    put(encI(32'h305, 11, 3'b001, 0, oSystem));
    put(encI(32'h305, 0, 3'b010, 15, oSystem));
    storeWord(15, 32'h200, 3);
    p = progPc;
    put(32'h0000_0073);
    saved  = progPc;
    progPc = 32'h200;
    put(encI(32'h341, 0, 3'b010, 12, oSystem));
    put(encI(32'h342, 0, 3'b010, 13, oSystem));
    storeWord(12, p, 3);
    storeWord(13, 32'd11, 3);
    // step mepc past the ecall before returning
    put(encI(32'd4, 12, 3'b000, 12, oOpImm));
    put(encI(32'h341, 12, 3'b001, 0, oSystem));
    put(32'h3020_0073);
    progPc = saved;
    storeWord(1, 32'd100, 3);
    put(32'h0010_0073);
    storeWrong(1);
  endtask

  // data port store checks
  always @(negedge clk) begin : storeCheck
    storeT       e;
    logic [31:0] mask;
    if (arstN && dReq.psel && dReq.penable && dRsp.pready && dReq.pwrite) begin
      if (expQ.size() == 0) begin
        $display("Unexpected store to address %h after the last expected one", dReq.paddr);
        strayErr++;
      end else begin
        e    = expQ.pop_front();
        mask = strbMask(e.strb);
        assert (dReq.paddr == e.addr) else begin
          $display("Mismatch %s paddr expected %h actual %h", names[e.test], e.addr, dReq.paddr);
          testErr[e.test]++;
        end
        assert (dReq.pstrb == e.strb) else begin
          $display("Mismatch %s pstrb expected %b actual %b", names[e.test], e.strb, dReq.pstrb);
          testErr[e.test]++;
        end
        assert ((dReq.pwdata & mask) == e.data) else begin
          $display("Mismatch %s pwdata expected %h actual %h", names[e.test], e.data,
                   dReq.pwdata & mask);
          testErr[e.test]++;
        end
        if (expQ.size() == 0 || expQ[0].test != e.test) begin
          reportTest(e.test);
        end
      end
    end
  end

  // request must hold through wait states
  always @(negedge clk) begin
    if (arstN) begin
      assert (!waitI || iReq == prevI) else begin
        $display("Instruction request changed while pready was low");
        testErr[5]++;
      end
      assert (!waitD || dReq == prevD) else begin
        $display("Data request changed while pready was low");
        testErr[5]++;
      end
      // instruction port is read only
      assert (!iReq.psel || !iReq.pwrite) else begin
        $display("Instruction port issued a write transfer");
        testErr[5]++;
      end
    end
    waitI = iReq.psel && iReq.penable && !iRsp.pready;
    waitD = dReq.psel && dReq.penable && !dRsp.pready;
    prevI = iReq;
    prevD = dReq;
  end

  initial begin
    int cyc;
    arstN = 1'b0;
    #1;
    buildProgram();
    repeat (16) @(posedge clk);
    arstN <= 1'b1;
    cyc = 0;
    while (!halted && cyc < 20000) begin
      @(negedge clk);
      cyc++;
    end
    if (!halted) begin
      $display("Timeout: the core did not halt within %0d cycles", cyc);
      $display("Simulation failed");
      $finish;
    end else begin
      for (int t = 0; t < 4; t++) begin
        if (!reported[t]) begin
          $display("Test %s did not perform all of its stores", names[t]);
          testErr[t]++;
          reportTest(t);
        end
      end
      // quiet window after ebreak
      cyc = 0;
      while (cyc < 100) begin
        @(negedge clk);
        assert (!iReq.psel && !dReq.psel && halted) else begin
          $display("Bus activity or halted drop after ebreak");
          testErr[4]++;
        end
        cyc++;
      end
      reportTest(4);
      reportTest(5);
      $display("tests passed %0d failed %0d, stray stores %0d", passCount, failCount,
               strayErr);
      if (failCount == 0 && strayErr == 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the rvCore testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

mkdir -p build
if ! verilator --binary --timing --assert -Wno-fatal -f rvCore.f \
    --top-module tbRvCore -Mdir build/obj -o simv > build/compile.log 2>&1; then
  echo "compile failed, see build/compile.log"
  exit 1
fi

if ! ./build/obj/simv > build/sim.log 2>&1; then
  cat build/sim.log
  echo "simulation run returned an error"
  exit 1
fi
cat build/sim.log

if grep -q "Simulation failed" build/sim.log; then
  exit 1
fi
exit 0

// ==== rvCore.f ====
src/rvPkg.sv
src/fetchUnit.sv
src/decoder.sv
src/execStage.sv
src/regFile.sv
src/csrFile.sv
src/loadStore.sv
src/rvCore.sv
bench/apbMem.sv
bench/tbRvCore.sv

// ==== src/csrFile.sv ====
`timescale 1ns/1ps

module csrFile (
  input  logic        clk,
  input  logic        arstN,
  input  logic        commit,
  input  rvPkg::ctrlT ctrl,
  input  logic [31:0] pc,
  input  logic [31:0] wdata,
  output logic [31:0] rdata,
  output logic [31:0] mtvec,
  output logic [31:0] mepc
);

  import rvPkg::*;

  logic [31:0] mcause;
  logic [31:0] newVal;

  always_comb begin
    case (ctrl.csrId)
      csrMtvec:  rdata = mtvec;
      csrMepc:   rdata = mepc;
      csrMcause: rdata = mcause;
      default:   rdata = 32'h0;
    endcase
  end

  // csrrs ors into the old value
  assign newVal = ctrl.csrSet ? (rdata | wdata) : wdata;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mtvec  <= 32'h0;
      mepc   <= 32'h0;
      mcause <= 32'h0;
    end else if (commit) begin
      if (ctrl.ecall) begin
        mepc   <= pc;
        mcause <= 32'd11;
      end else if (ctrl.csrEn) begin
        case (ctrl.csrId)
          csrMtvec:  mtvec  <= newVal;
          csrMepc:   mepc   <= newVal;
          csrMcause: mcause <= newVal;
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== src/decoder.sv ====
`timescale 1ns/1ps

module decoder (
  input  logic [31:0] inst,
  output rvPkg::ctrlT ctrl
);

  import rvPkg::*;

  logic [2:0]  funct3;
  logic        funct7b5;
  logic [31:0] immI;
  logic [31:0] immS;
  logic [31:0] immB;
  logic [31:0] immU;
  logic [31:0] immJ;

  assign funct3   = inst[14:12];
  assign funct7b5 = inst[30];

  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'h000};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // shared by op and opImm, sub only exists for register form
  function automatic aluOpE arithOp(input logic [2:0] f3, input logic alt, input logic isReg);
    aluOpE op;
    case (f3)
      3'b000:  op = (isReg && alt) ? aluSub : aluAdd;
      3'b001:  op = aluSll;
      3'b010:  op = aluSlt;
      3'b011:  op = aluSltu;
      3'b100:  op = aluXor;
      3'b101:  op = alt ? aluSra : aluSrl;
      3'b110:  op = aluOr;
      default: op = aluAnd;
    endcase
    return op;
  endfunction

  always_comb begin
    ctrl         = '0;
    ctrl.aluOp   = aluAdd;
    ctrl.aluBSel = bImm;
    ctrl.wbSel   = wbAlu;
    ctrl.brFunct = funct3;
    case (opcodeE'(inst[6:0]))
      opcOp: begin
        ctrl.aluOp    = arithOp(funct3, funct7b5, 1'b1);
        ctrl.aluBSel  = bReg;
        ctrl.regWrite = 1'b1;
      end
      opcOpImm: begin
        ctrl.aluOp    = arithOp(funct3, funct7b5, 1'b0);
        ctrl.imm      = immI;
        ctrl.regWrite = 1'b1;
      end
      opcLoad: begin
        ctrl.imm         = immI;
        ctrl.memRead     = 1'b1;
        ctrl.memSize     = funct3[1:0];
        ctrl.memUnsigned = funct3[2];
        ctrl.regWrite    = 1'b1;
        ctrl.wbSel       = wbMem;
      end
      opcStore: begin
        ctrl.imm      = immS;
        ctrl.memWrite = 1'b1;
        ctrl.memSize  = funct3[1:0];
      end
      opcBranch: begin
        ctrl.aluASel = 1'b1;
        ctrl.imm     = immB;
        ctrl.branch  = 1'b1;
      end
      opcJal: begin
        ctrl.aluASel  = 1'b1;
        ctrl.imm      = immJ;
        ctrl.jump     = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.wbSel    = wbPcPlus4;
      end
      opcJalr: begin
        ctrl.imm      = immI;
        ctrl.jump     = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.wbSel    = wbPcPlus4;
      end
      opcLui: begin
        ctrl.aluOp    = aluPassB;
        ctrl.imm      = immU;
        ctrl.regWrite = 1'b1;
      end
      opcAuipc: begin
        ctrl.aluASel  = 1'b1;
        ctrl.imm      = immU;
        ctrl.regWrite = 1'b1;
      end
      opcSystem: begin
        if (funct3 == 3'b000) begin
          ctrl.ecall  = (inst[31:20] == 12'h000);
          ctrl.ebreak = (inst[31:20] == 12'h001);
          ctrl.mret   = (inst[31:20] == 12'h302);
        end else if (funct3 == 3'b001 || funct3 == 3'b010) begin
          // csrrw / csrrs, old value goes to rd
          ctrl.aluOp    = aluPassB;
          ctrl.aluBSel  = bCsr;
          ctrl.csrEn    = 1'b1;
          ctrl.csrSet   = funct3[1];
          ctrl.csrId    = inst[31:20];
          ctrl.regWrite = 1'b1;
          ctrl.wbSel    = wbCsr;
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== src/execStage.sv ====
`timescale 1ns/1ps

module execStage (
  input  rvPkg::ctrlT ctrl,
  input  logic [31:0] pc,
  input  logic [31:0] rs1Data,
  input  logic [31:0] rs2Data,
  input  logic [31:0] csrRdata,
  input  logic [31:0] memData,
  input  logic [31:0] mtvec,
  input  logic [31:0] mepc,
  output logic [31:0] aluOut,
  output logic [31:0] nextPc,
  output logic [31:0] wbData
);

  import rvPkg::*;

  logic [31:0] opA;
  logic [31:0] opB;
  logic [4:0]  shamt;
  logic [31:0] pcPlus4;
  logic        brEq;
  logic        brLt;
  logic        brTaken;

  assign pcPlus4 = pc + 32'd4;

  // operand select
  assign opA = ctrl.aluASel ? pc : rs1Data;

  always_comb begin
    case (ctrl.aluBSel)
      bReg:    opB = rs2Data;
      bCsr:    opB = csrRdata;
      default: opB = ctrl.imm;
    endcase
  end

  assign shamt = opB[4:0];

  always_comb begin
    case (ctrl.aluOp)
      aluSub:   aluOut = opA - opB;
      aluSll:   aluOut = opA << shamt;
      aluSlt:   aluOut = {31'h0, $signed(opA) < $signed(opB)};
      aluSltu:  aluOut = {31'h0, opA < opB};
      aluXor:   aluOut = opA ^ opB;
      aluSrl:   aluOut = opA >> shamt;
      aluSra:   aluOut = $unsigned($signed(opA) >>> shamt);
      aluOr:    aluOut = opA | opB;
      aluAnd:   aluOut = opA & opB;
      aluPassB: aluOut = opB;
      default:  aluOut = opA + opB;
    endcase
  end

  // branch compare, funct3[1] picks unsigned, funct3[0] inverts
  assign brEq    = (rs1Data == rs2Data);
  assign brLt    = ctrl.brFunct[1] ? (rs1Data < rs2Data)
                                   : ($signed(rs1Data) < $signed(rs2Data));
  assign brTaken = ctrl.brFunct[2] ? (brLt ^ ctrl.brFunct[0]) : (brEq ^ ctrl.brFunct[0]);

  always_comb begin
    if (ctrl.mret) begin
      nextPc = mepc;
    end else if (ctrl.ecall) begin
      nextPc = mtvec;
    end else if (ctrl.jump || (ctrl.branch && brTaken)) begin
      // jalr needs bit 0 cleared, other targets are already even
      nextPc = {aluOut[31:1], 1'b0};
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_comb begin
    case (ctrl.wbSel)
      wbMem:     wbData = memData;
      wbPcPlus4: wbData = pcPlus4;
      wbCsr:     wbData = csrRdata;
      default:   wbData = aluOut;
    endcase
  end

endmodule

// ==== src/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit #(
  parameter logic [31:0] resetPc = 32'h0
) (
  input  logic          clk,
  input  logic          arstN,
  input  logic          start,
  input  logic          commit,
  input  logic [31:0]   nextPc,
  output logic [31:0]   pc,
  output logic [31:0]   inst,
  output logic          fetchDone,
  output logic          fault,
  output rvPkg::apbReqT iReq,
  input  rvPkg::apbRspT iRsp
);

  logic psel;
  logic penable;
  logic xferEnd;

  // access phase finishing this cycle
  assign xferEnd   = penable & iRsp.pready;
  assign fetchDone = xferEnd & ~iRsp.pslverr;
  assign fault     = xferEnd & iRsp.pslverr;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      psel    <= 1'b0;
      penable <= 1'b0;
      pc      <= resetPc;
    end else begin
      if (start) begin
        psel    <= 1'b1;
        penable <= 1'b0;
      end else if (psel && !penable) begin
        penable <= 1'b1;
      end else if (xferEnd) begin
        psel    <= 1'b0;
        penable <= 1'b0;
      end
      if (commit) begin
        pc <= nextPc;
      end
    end
  end

  // instruction held until the next fetch completes
  always_ff @(posedge clk) begin
    if (xferEnd) begin
      inst <= iRsp.prdata;
    end
  end

  always_comb begin
    iReq.paddr   = pc;
    iReq.psel    = psel;
    iReq.penable = penable;
    iReq.pwrite  = 1'b0;
    iReq.pwdata  = 32'h0;
    iReq.pstrb   = 4'h0;
  end

endmodule

// ==== src/loadStore.sv ====
`timescale 1ns/1ps

module loadStore (
  input  logic          clk,
  input  logic          arstN,
  input  logic          start,
  input  rvPkg::ctrlT   ctrl,
  input  logic [31:0]   addr,
  input  logic [31:0]   storeData,
  output logic [31:0]   loadData,
  output logic          memDone,
  output logic          fault,
  output rvPkg::apbReqT dReq,
  input  rvPkg::apbRspT dRsp
);

  logic        psel;
  logic        penable;
  logic        xferEnd;
  logic [31:0] paddr;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic [31:0] laneData;

  assign xferEnd = penable & dRsp.pready;
  assign memDone = xferEnd & ~dRsp.pslverr;
  assign fault   = xferEnd & dRsp.pslverr;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      psel    <= 1'b0;
      penable <= 1'b0;
    end else if (start) begin
      psel    <= 1'b1;
      penable <= 1'b0;
    end else if (psel && !penable) begin
      penable <= 1'b1;
    end else if (xferEnd) begin
      psel    <= 1'b0;
      penable <= 1'b0;
    end
  end

  // request captured at start, lanes replicated and strobed
  always_ff @(posedge clk) begin
    if (start) begin
      paddr  <= addr;
      pwrite <= ctrl.memWrite;
      case (ctrl.memSize)
        2'b00: begin
          pwdata <= {4{storeData[7:0]}};
          pstrb  <= 4'b0001 << addr[1:0];
        end
        2'b01: begin
          pwdata <= {2{storeData[15:0]}};
          pstrb  <= 4'b0011 << {addr[1], 1'b0};
        end
        default: begin
          pwdata <= storeData;
          pstrb  <= 4'b1111;
        end
      endcase
    end
  end

  assign dReq = '{paddr: paddr, psel: psel, penable: penable, pwrite: pwrite,
                  pwdata: pwdata, pstrb: pstrb};

  // move the addressed lane down, then extend
  assign laneData = dRsp.prdata >> {paddr[1:0], 3'b000};

  always_comb begin
    case (ctrl.memSize)
      2'b00:   loadData = {{24{laneData[7] & ~ctrl.memUnsigned}}, laneData[7:0]};
      2'b01:   loadData = {{16{laneData[15] & ~ctrl.memUnsigned}}, laneData[15:0]};
      default: loadData = dRsp.prdata;
    endcase
  end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile (
  input  logic        clk,
  input  logic        arstN,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        we,
  input  logic [31:0] wdata,
  output logic [31:0] rs1Data,
  output logic [31:0] rs2Data
);

  // x0 is not stored
  logic [31:0] regs [1:31];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= 32'h0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1Data = (rs1 == 5'd0) ? 32'h0 : regs[rs1];
  assign rs2Data = (rs2 == 5'd0) ? 32'h0 : regs[rs2];

endmodule

// ==== src/rvCore.sv ====
`timescale 1ns/1ps

module rvCore #(
  parameter logic [31:0] resetPc = 32'h0
) (
  input  logic          clk,
  input  logic          arstN,
  output rvPkg::apbReqT iReq,
  input  rvPkg::apbRspT iRsp,
  output rvPkg::apbReqT dReq,
  input  rvPkg::apbRspT dRsp,
  output logic          halted
);

  import rvPkg::*;

  coreStateE   state;
  ctrlT        ctrl;
  logic        firstFetch;
  logic        fetchStart;
  logic        memStart;
  logic        commit;
  logic        isMem;
  logic        fetchDone;
  logic        iFault;
  logic        memDone;
  logic        dFault;
  logic [31:0] pc;
  logic [31:0] inst;
  logic [31:0] nextPc;
  logic [31:0] aluOut;
  logic [31:0] wbData;
  logic [31:0] rs1Data;
  logic [31:0] rs2Data;
  logic [31:0] csrRdata;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] loadData;

  assign isMem    = ctrl.memRead | ctrl.memWrite;
  assign memStart = (state == stExecute) & isMem;

  // loads and stores commit on memDone, everything else leaves execute
  always_comb begin
    case (state)
      stExecute: commit = ~ctrl.ebreak & ~isMem;
      stMemory:  commit = memDone;
      default:   commit = 1'b0;
    endcase
  end

  // next fetch setup starts on the commit edge
  assign fetchStart = firstFetch | commit;
  assign halted     = (state == stHalted);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state      <= stFetch;
      firstFetch <= 1'b1;
    end else begin
      firstFetch <= 1'b0;
      case (state)
        stFetch: begin
          if (iFault) begin
            state <= stHalted;
          end else if (fetchDone) begin
            state <= stExecute;
          end
        end
        stExecute: begin
          if (ctrl.ebreak) begin
            state <= stHalted;
          end else if (isMem) begin
            state <= stMemory;
          end else begin
            state <= stFetch;
          end
        end
        stMemory: begin
          if (dFault) begin
            state <= stHalted;
          end else if (memDone) begin
            state <= stFetch;
          end
        end
        default: state <= stHalted;
      endcase
    end
  end

  fetchUnit #(.resetPc(resetPc)) u_fetch (
    .clk(clk), .arstN(arstN), .start(fetchStart), .commit(commit),
    .nextPc(nextPc), .pc(pc), .inst(inst), .fetchDone(fetchDone),
    .fault(iFault), .iReq(iReq), .iRsp(iRsp)
  );

  decoder u_decoder (.inst(inst), .ctrl(ctrl));

  execStage u_exec (
    .ctrl(ctrl), .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data),
    .csrRdata(csrRdata), .memData(loadData), .mtvec(mtvec), .mepc(mepc),
    .aluOut(aluOut), .nextPc(nextPc), .wbData(wbData)
  );

  regFile u_regs (
    .clk(clk), .arstN(arstN), .rs1(inst[19:15]), .rs2(inst[24:20]),
    .rd(inst[11:7]), .we(commit & ctrl.regWrite), .wdata(wbData),
    .rs1Data(rs1Data), .rs2Data(rs2Data)
  );

  csrFile u_csr (
    .clk(clk), .arstN(arstN), .commit(commit), .ctrl(ctrl), .pc(pc),
    .wdata(rs1Data), .rdata(csrRdata), .mtvec(mtvec), .mepc(mepc)
  );

  loadStore u_lsu (
    .clk(clk), .arstN(arstN), .start(memStart), .ctrl(ctrl), .addr(aluOut),
    .storeData(rs2Data), .loadData(loadData), .memDone(memDone),
    .fault(dFault), .dReq(dReq), .dRsp(dRsp)
  );

endmodule

// ==== src/rvPkg.sv ====
package rvPkg;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    opcOp     = 7'b0110011,
    opcOpImm  = 7'b0010011,
    opcLoad   = 7'b0000011,
    opcStore  = 7'b0100011,
    opcBranch = 7'b1100011,
    opcJal    = 7'b1101111,
    opcJalr   = 7'b1100111,
    opcLui    = 7'b0110111,
    opcAuipc  = 7'b0010111,
    opcSystem = 7'b1110011
  } opcodeE;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
    aluSrl, aluSra, aluOr, aluAnd, aluPassB
  } aluOpE;

  typedef enum logic [1:0] {bReg, bImm, bCsr} aluBSelE;

  typedef enum logic [1:0] {wbMem, wbAlu, wbPcPlus4, wbCsr} wbSelE;

  typedef enum logic [1:0] {stFetch, stExecute, stMemory, stHalted} coreStateE;

  // machine CSR addresses
  localparam logic [11:0] csrMtvec  = 12'h305;
  localparam logic [11:0] csrMepc   = 12'h341;
  localparam logic [11:0] csrMcause = 12'h342;

  typedef struct packed {
    aluOpE       aluOp;
    logic        aluASel;      // 1 selects pc
    aluBSelE     aluBSel;
    logic        branch;
    logic [2:0]  brFunct;
    logic        jump;
    logic        memRead;
    logic        memWrite;
    logic [1:0]  memSize;      // byte, half, word
    logic        memUnsigned;
    logic        regWrite;
    wbSelE       wbSel;
    logic        csrEn;
    logic        csrSet;
    logic [11:0] csrId;
    logic        ecall;
    logic        mret;
    logic        ebreak;
    logic [31:0] imm;
  } ctrlT;

  typedef struct packed {
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
  } apbReqT;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apbRspT;

endpackage
